/* flist.f */
source/frame_link_pkg.sv
source/source_arbiter.sv
source/record_fifo.sv
source/record_serializer.sv
source/byte_uart_tx.sv
source/tdc_frame_link.sv
verification/tb_link_checker.sv
verification/tb_tdc_frame_link.sv

/* run_sim.sh */
#!/bin/sh
# Build the tdc_frame_link testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps \
        --top-module tb_tdc_frame_link -f flist.f -o sim_tdc_frame_link; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tdc_frame_link)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The run counts as passed only if the pass line is present
if echo "$sim_out" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* source/byte_uart_tx.sv */
`timescale 1ns/100ps

module byte_uart_tx (
    input  logic clk,
    input  logic rst,
    input  logic byte_start,
    input  logic [7:0] byte_data,
    output logic tx,
    output logic uart_busy
);
    import frame_link_pkg::*;

    logic [$clog2(CLK_PER_BIT)-1:0] clk_cnt;
    logic [3:0]                     bit_idx;
    logic [8:0]                     shift_reg;   // Data bits then stop bit

    always_ff @(posedge clk) begin
        if (rst) begin
            tx        <= 1'b1;   // Line idles high
            uart_busy <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
        end else if (!uart_busy) begin
            if (byte_start) begin
                tx        <= 1'b0;   // Start bit
                uart_busy <= 1'b1;
                clk_cnt   <= '0;
                bit_idx   <= '0;
            end
        end else if (clk_cnt == ($clog2(CLK_PER_BIT))'(CLK_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                uart_busy <= 1'b0;   // Stop bit done
                tx        <= 1'b1;
            end else begin
                tx      <= shift_reg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!uart_busy && byte_start) begin
            shift_reg <= {1'b1, byte_data};
        end else if (uart_busy && clk_cnt == ($clog2(CLK_PER_BIT))'(CLK_PER_BIT - 1)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

/* source/frame_link_pkg.sv */
package frame_link_pkg;

    localparam int NUM_SOURCES  = 6;
    localparam int SAMPLE_W     = 32;
    localparam int FIELD_W      = 16;
    localparam int RECORD_W     = 48;
    localparam int RECORD_BYTES = 6;
    localparam int FIFO_ADDR_W  = 4;   // 16 records deep
    localparam int CLK_PER_BIT  = 8;   // Simulation baud

    localparam logic [FIELD_W-1:0] LINE_CODE  = 16'h000D;
    localparam logic [FIELD_W-1:0] FRAME_CODE = 16'h000E;

    // Serializer FSM encoding
    localparam logic [1:0] SER_IDLE  = 2'd0;
    localparam logic [1:0] SER_FETCH = 2'd1;
    localparam logic [1:0] SER_LOAD  = 2'd2;
    localparam logic [1:0] SER_SEND  = 2'd3;

    // One 48-bit record, read either as a TDC sample or as a marker
    typedef union packed {
        struct packed {
            logic [SAMPLE_W-1:0] sample;
            logic [FIELD_W-1:0]  source_id;   // 1-based
        } smp;
        struct packed {
            logic [FIELD_W-1:0] code_hi;
            logic [FIELD_W-1:0] code_lo;
            logic [FIELD_W-1:0] source_id;
        } mrk;
    } frame_record_t;

endpackage

/* source/record_fifo.sv */
`timescale 1ns/100ps

module record_fifo (
    input  logic clk,
    input  logic rst,
    input  logic wr_en,
    input  logic [frame_link_pkg::RECORD_W-1:0] wr_record,
    input  logic rd_en,
    output logic [frame_link_pkg::RECORD_W-1:0] rd_record,
    output logic empty,
    output logic full
);
    import frame_link_pkg::*;

    logic [RECORD_W-1:0]    mem [2**FIFO_ADDR_W];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W:0]   count;   // One extra bit for full
    logic                   do_wr;
    logic                   do_rd;

    assign empty = (count == '0);
    assign full  = count[FIFO_ADDR_W];
    assign do_wr = wr_en && !full;    // Dropped when full
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_record;
        end
    end

    // Registered read, held until the next read
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_record <= mem[rd_ptr];
        end
    end

endmodule

/* source/record_serializer.sv */
`timescale 1ns/100ps

module record_serializer (
    input  logic clk,
    input  logic rst,
    input  logic empty,
    input  logic [frame_link_pkg::RECORD_W-1:0] rd_record,
    input  logic uart_busy,
    output logic rd_en,
    output logic byte_start,
    output logic [7:0] byte_data,
    output logic tx_busy
);
    import frame_link_pkg::*;

    logic [1:0]                           state;
    logic [RECORD_W-1:0]                  shift_reg;
    logic [$clog2(RECORD_BYTES+1)-1:0]    byte_cnt;

    assign tx_busy = (state != SER_IDLE) || uart_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SER_IDLE;
            rd_en      <= 1'b0;
            byte_start <= 1'b0;
            byte_cnt   <= '0;
        end else begin
            rd_en      <= 1'b0;
            byte_start <= 1'b0;
            case (state)
                SER_IDLE: begin
                    if (!empty) begin
                        rd_en <= 1'b1;
                        state <= SER_FETCH;
                    end
                end
                SER_FETCH: state <= SER_LOAD;   // FIFO output registers now
                SER_LOAD: begin
                    byte_cnt <= '0;
                    state    <= SER_SEND;
                end
                default: begin
                    // byte_start check covers the cycle before busy rises
                    if (!uart_busy && !byte_start) begin
                        if (byte_cnt == ($clog2(RECORD_BYTES+1))'(RECORD_BYTES)) begin
                            if (!empty) begin
                                rd_en <= 1'b1;   // Next record straight away
                                state <= SER_FETCH;
                            end else begin
                                state <= SER_IDLE;
                            end
                        end else begin
                            byte_start <= 1'b1;
                            byte_cnt   <= byte_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == SER_LOAD) begin
            shift_reg <= rd_record;
        end else if (state == SER_SEND && !uart_busy && !byte_start) begin
            byte_data <= shift_reg[7:0];
            shift_reg <= shift_reg >> 8;
        end
    end

endmodule

/* source/source_arbiter.sv */
`timescale 1ns/100ps

module source_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] sample_wr,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] line_req,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] frame_req,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0][frame_link_pkg::SAMPLE_W-1:0] sample_din,
    output logic [frame_link_pkg::NUM_SOURCES-1:0] sample_done,
    output logic [frame_link_pkg::NUM_SOURCES-1:0] line_done,
    output logic [frame_link_pkg::NUM_SOURCES-1:0] frame_done,
    output logic wr_en,
    output frame_link_pkg::frame_record_t wr_record
);
    import frame_link_pkg::*;

    logic          grant;
    frame_record_t grant_record;

    function automatic frame_record_t marker_record(input logic [FIELD_W-1:0] code,
                                                    input int src);
        frame_record_t rec;
        rec.mrk.code_hi   = code;
        rec.mrk.code_lo   = code;
        rec.mrk.source_id = FIELD_W'(src + 1);
        return rec;
    endfunction

    // Source 1 first; within a source sample, line, frame
    always_comb begin
        sample_done  = '0;
        line_done    = '0;
        frame_done   = '0;
        grant        = 1'b0;
        grant_record = '0;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            if (!grant) begin
                if (sample_wr[i]) begin
                    grant                     = 1'b1;
                    sample_done[i]            = 1'b1;
                    grant_record.smp.sample    = sample_din[i];
                    grant_record.smp.source_id = FIELD_W'(i + 1);
                end else if (line_req[i]) begin
                    grant        = 1'b1;
                    line_done[i] = 1'b1;
                    grant_record = marker_record(LINE_CODE, i);
                end else if (frame_req[i]) begin
                    grant         = 1'b1;
                    frame_done[i] = 1'b1;
                    grant_record  = marker_record(FRAME_CODE, i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= grant;
        end
    end

    always_ff @(posedge clk) begin
        wr_record <= grant_record;   // Qualified by wr_en
    end

endmodule

/* source/tdc_frame_link.sv */
`timescale 1ns/100ps

module tdc_frame_link (
    input  logic clk,
    input  logic rst,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] sample_wr,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] line_req,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] frame_req,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0][frame_link_pkg::SAMPLE_W-1:0] sample_din,
    output logic [frame_link_pkg::NUM_SOURCES-1:0] sample_done,
    output logic [frame_link_pkg::NUM_SOURCES-1:0] line_done,
    output logic [frame_link_pkg::NUM_SOURCES-1:0] frame_done,
    output logic tx,
    output logic tx_busy
);
    import frame_link_pkg::*;

    logic                wr_en;
    logic [RECORD_W-1:0] wr_record;
    logic                rd_en;
    logic [RECORD_W-1:0] rd_record;
    logic                empty;
    logic                byte_start;
    logic [7:0]          byte_data;
    logic                uart_busy;

    source_arbiter source_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .sample_wr   (sample_wr),
        .line_req    (line_req),
        .frame_req   (frame_req),
        .sample_din  (sample_din),
        .sample_done (sample_done),
        .line_done   (line_done),
        .frame_done  (frame_done),
        .wr_en       (wr_en),
        .wr_record   (wr_record)
    );

    // Full only matters inside the FIFO, where writes are dropped
    record_fifo record_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_record (wr_record),
        .rd_en     (rd_en),
        .rd_record (rd_record),
        .empty     (empty),
        .full      ()
    );

    record_serializer record_serializer_i (
        .clk        (clk),
        .rst        (rst),
        .empty      (empty),
        .rd_record  (rd_record),
        .uart_busy  (uart_busy),
        .rd_en      (rd_en),
        .byte_start (byte_start),
        .byte_data  (byte_data),
        .tx_busy    (tx_busy)
    );

    byte_uart_tx byte_uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .byte_start (byte_start),
        .byte_data  (byte_data),
        .tx         (tx),
        .uart_busy  (uart_busy)
    );

endmodule

/* verification/tb_link_checker.sv */
`timescale 1ns/100ps

module tb_link_checker (
    input  logic clk,
    input  logic rst,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] sample_done,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] line_done,
    input  logic [frame_link_pkg::NUM_SOURCES-1:0] frame_done,
    input  logic tx,
    input  logic exp_done_valid,
    input  logic [3*frame_link_pkg::NUM_SOURCES-1:0] exp_done,
    input  logic exp_rec_valid,
    input  logic [frame_link_pkg::RECORD_W-1:0] exp_rec,
    output int error_count,
    output int check_count,
    output int pending
);
    import frame_link_pkg::*;

    localparam int HALF_BIT = CLK_PER_BIT / 2;

    string               test_name = "none";
    logic [RECORD_W-1:0] exp_q[$];   // Granted records in grant order
    logic [RECORD_W-1:0] rx_rec;
    logic [7:0]          rx_byte;
    logic                rx_active = 1'b0;
    int                  rx_cnt = 0;   // Cycles since the start edge
    int                  byte_idx = 0;
    int                  errors = 0;
    int                  checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic check_record();
        logic [RECORD_W-1:0] expected;
        checks++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s: a record arrived on tx with no granted request behind it", test_name);
        end else begin
            expected = exp_q.pop_front();
            if (rx_rec !== expected) begin
                errors++;
                $display("[FAIL] %s record: expected %h actual %h", test_name, expected, rx_rec);
            end
        end
    endtask

    // pos 0 is the start bit, 1 to 8 data LSB first, 9 the stop bit
    task automatic sample_bit(input int pos);
        if (pos == 0) begin
            if (tx) begin
                errors++;
                rx_active = 1'b0;
                $display("%s: start bit on tx ended before mid-bit", test_name);
            end
        end else if (pos <= 8) begin
            rx_byte[pos-1] = tx;
        end else begin
            rx_active = 1'b0;
            if (!tx) begin
                errors++;
                $display("%s: bad stop bit after byte %0d of a record", test_name, byte_idx);
            end
            rx_rec[8*byte_idx +: 8] = rx_byte;
            byte_idx++;
            if (byte_idx == RECORD_BYTES) begin
                byte_idx = 0;
                check_record();
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            rx_active = 1'b0;
            byte_idx  = 0;
        end else begin
            if (exp_done_valid) begin
                checks++;
                if ({sample_done, line_done, frame_done} !== exp_done) begin
                    errors++;
                    $display("[FAIL] %s done vector: expected %h actual %h",
                             test_name, exp_done, {sample_done, line_done, frame_done});
                end
            end
            if (exp_rec_valid) exp_q.push_back(exp_rec);
            if (!rx_active) begin
                if (!tx) begin
                    rx_active = 1'b1;
                    rx_cnt    = 0;
                end
            end else begin
                rx_cnt++;
                if (rx_cnt % CLK_PER_BIT == HALF_BIT) sample_bit(rx_cnt / CLK_PER_BIT);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* verification/tb_tdc_frame_link.sv */
`timescale 1ns/100ps

module tb_tdc_frame_link;
    import frame_link_pkg::*;

    localparam int     MAX_RECORDS = 60;   // 6 + 12 + 3 x 10 + 12
    localparam int     DONE_W      = 3 * NUM_SOURCES;
    localparam longint WATCHDOG_NS = longint'(MAX_RECORDS + 10) * 64 * CLK_PER_BIT * 4;

    logic                                 clk = 1'b0;
    logic                                 rst;
    logic [NUM_SOURCES-1:0]               sample_wr;
    logic [NUM_SOURCES-1:0]               line_req;
    logic [NUM_SOURCES-1:0]               frame_req;
    logic [NUM_SOURCES-1:0][SAMPLE_W-1:0] sample_din;
    logic [NUM_SOURCES-1:0]               sample_done;
    logic [NUM_SOURCES-1:0]               line_done;
    logic [NUM_SOURCES-1:0]               frame_done;
    logic                                 tx;
    logic                                 tx_busy;

    logic              exp_done_valid;
    logic [DONE_W-1:0] exp_done;
    logic              exp_rec_valid;
    frame_record_t     exp_rec;
    int                link_errors;
    int                link_checks;
    int                link_pending;

    logic [31:0] rng = 32'd97193;
    string       current_test = "none";
    int          tb_errors = 0;
    int          tb_checks = 0;
    int          tests_run = 0;
    int          errors_at_start = 0;

    always #2 clk = ~clk;

    tdc_frame_link tdc_frame_link_i (
        .clk         (clk),
        .rst         (rst),
        .sample_wr   (sample_wr),
        .line_req    (line_req),
        .frame_req   (frame_req),
        .sample_din  (sample_din),
        .sample_done (sample_done),
        .line_done   (line_done),
        .frame_done  (frame_done),
        .tx          (tx),
        .tx_busy     (tx_busy)
    );

    tb_link_checker link_checker_i (
        .clk            (clk),
        .rst            (rst),
        .sample_done    (sample_done),
        .line_done      (line_done),
        .frame_done     (frame_done),
        .tx             (tx),
        .exp_done_valid (exp_done_valid),
        .exp_done       (exp_done),
        .exp_rec_valid  (exp_rec_valid),
        .exp_rec        (exp_rec),
        .error_count    (link_errors),
        .check_count    (link_checks),
        .pending        (link_pending)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Lowest source wins and within it sample beats line beats frame
    function automatic logic expected_grant(
        input  logic [NUM_SOURCES-1:0]               sw,
        input  logic [NUM_SOURCES-1:0]               lr,
        input  logic [NUM_SOURCES-1:0]               fr,
        input  logic [NUM_SOURCES-1:0][SAMPLE_W-1:0] din,
        output int                                   src,
        output int                                   kind,
        output frame_record_t                        rec
    );
        src  = -1;
        kind = -1;
        rec  = '0;
        for (int s = 0; s < NUM_SOURCES; s++) begin
            if (src < 0) begin
                if (sw[s]) kind = 0;
                else if (lr[s]) kind = 1;
                else if (fr[s]) kind = 2;
                if (kind >= 0) src = s;
            end
        end
        if (kind == 0) begin
            rec.smp.sample    = din[src];
            rec.smp.source_id = 16'(src + 1);
        end else if (kind > 0) begin
            rec.mrk.code_hi   = (kind == 1) ? LINE_CODE : FRAME_CODE;
            rec.mrk.code_lo   = (kind == 1) ? LINE_CODE : FRAME_CODE;
            rec.mrk.source_id = 16'(src + 1);
        end
        return (src >= 0);
    endfunction

    task automatic drive_cycle(
        input logic [NUM_SOURCES-1:0]               sw,
        input logic [NUM_SOURCES-1:0]               lr,
        input logic [NUM_SOURCES-1:0]               fr,
        input logic [NUM_SOURCES-1:0][SAMPLE_W-1:0] din
    );
        int            src;
        int            kind;
        frame_record_t rec;
        logic          granted;
        @(negedge clk);
        sample_wr  = sw;
        line_req   = lr;
        frame_req  = fr;
        sample_din = din;
        granted    = expected_grant(sw, lr, fr, din, src, kind, rec);
        exp_done   = '0;
        if (granted) exp_done[(2 - kind) * NUM_SOURCES + src] = 1'b1;  // {sample, line, frame}
        exp_done_valid = 1'b1;
        exp_rec_valid  = granted;
        exp_rec        = rec;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle('0, '0, '0, '0);
    endtask

    task automatic random_din(output logic [NUM_SOURCES-1:0][SAMPLE_W-1:0] din);
        for (int s = 0; s < NUM_SOURCES; s++) begin
            rng    = xorshift32(rng);
            din[s] = rng;
        end
    endtask

    task automatic one_request(input int src, input int kind);
        logic [NUM_SOURCES-1:0]               sw;
        logic [NUM_SOURCES-1:0]               lr;
        logic [NUM_SOURCES-1:0]               fr;
        logic [NUM_SOURCES-1:0][SAMPLE_W-1:0] din;
        sw = '0;
        lr = '0;
        fr = '0;
        case (kind)
            0:       sw[src] = 1'b1;
            1:       lr[src] = 1'b1;
            default: fr[src] = 1'b1;
        endcase
        random_din(din);
        drive_cycle(sw, lr, fr, din);
    endtask

    // About one request in four per source and kind
    task automatic random_request();
        logic [31:0]                          r1;
        logic [31:0]                          r2;
        logic [NUM_SOURCES-1:0][SAMPLE_W-1:0] din;
        rng = xorshift32(rng);
        r1  = rng;
        rng = xorshift32(rng);
        r2  = rng;
        random_din(din);
        drive_cycle(r1[5:0] & r1[13:8], r1[21:16] & r1[29:24], r2[5:0] & r2[13:8], din);
    endtask

    task automatic wait_drained();
        idle_cycles(2);
        while (link_pending != 0 || tx_busy) begin
            drive_cycle('0, '0, '0, '0);
        end
    endtask

    task automatic check_busy_held();
        logic seen_busy;
        logic dropped;
        seen_busy = 1'b0;
        dropped   = 1'b0;
        tb_checks++;
        while (link_pending != 0 || !seen_busy) begin
            drive_cycle('0, '0, '0, '0);
            if (tx_busy) begin
                seen_busy = 1'b1;
            end else if (seen_busy && link_pending != 0 && !dropped) begin
                dropped = 1'b1;
                tb_errors++;
                $display("[FAIL] %s tx_busy: expected 1 actual 0", current_test);
            end
        end
    endtask

    task automatic start_test(input string name);
        current_test             = name;
        link_checker_i.test_name = name;
        errors_at_start          = tb_errors + link_errors;
    endtask

    task automatic end_test();
        int errs;
        errs = tb_errors + link_errors - errors_at_start;
        tests_run++;
        if (errs == 0) $display("test %s: passed", current_test);
        else $display("test %s: failed with %0d errors", current_test, errs);
    endtask

    initial begin
        sample_wr      = '0;
        line_req       = '0;
        frame_req      = '0;
        sample_din     = '0;
        exp_done_valid = 1'b0;
        exp_done       = '0;
        exp_rec_valid  = 1'b0;
        exp_rec        = '0;
        rst            = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_idle");
        tb_checks++;
        if (tx !== 1'b1 || tx_busy !== 1'b0) begin
            tb_errors++;
            $display("[FAIL] reset_idle tx,tx_busy: expected 10 actual %b%b", tx, tx_busy);
        end
        idle_cycles(16);
        end_test();

        start_test("sample_each_source");
        for (int s = 0; s < NUM_SOURCES; s++) begin
            one_request(s, 0);
            wait_drained();
        end
        end_test();

        start_test("line_and_frame");
        for (int s = 0; s < NUM_SOURCES; s++) begin
            one_request(s, 1);
            wait_drained();
            one_request(s, 2);
            wait_drained();
        end
        end_test();

        start_test("random_contention");
        for (int round = 0; round < 3; round++) begin
            for (int c = 0; c < 10; c++) random_request();  // Stays under FIFO depth
            wait_drained();
        end
        end_test();

        start_test("burst_of_12");
        for (int c = 0; c < 12; c++) begin
            rng = xorshift32(rng);
            one_request(int'(rng % 32'd6), int'((rng >> 8) % 32'd3));
        end
        check_busy_held();
        wait_drained();
        end_test();

        $display("tests run: %0d, checks: %0d, errors: %0d",
                 tests_run, tb_checks + link_checks, tb_errors + link_errors);
        if (tb_errors + link_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout in test %s: %0d expected records never came out on tx",
                 current_test, link_pending);
        $display("** FAIL **");
        $finish;
    end

endmodule
